/* car_dispatch.sv */
/*
 * Car dispatch
 * Gates service on power and emergency, pops the head floor once the car
 * stands at it, and otherwise sends the car toward the head floor. Also
 * registers the door open and close permissions.
 */

`timescale 1ns/1ps

module car_dispatch
    import elevator_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   power_switch,
    input  logic                   emergency_btn,
    input  logic                   elevator_moving,
    input  logic [FLOOR_WIDTH-1:0] current_floor,
    input  logic [FLOOR_WIDTH-1:0] head_floor,
    input  logic                   queue_empty,
    input  logic                   door_open_btn,
    input  logic                   door_close_btn,
    output logic                   service_active,
    output logic                   arrival,
    output logic [FLOOR_WIDTH-1:0] elevator_floor_selector,
    output logic                   direction_selector,
    output logic                   activate_elevator,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);

    logic car_ready;
    logic go_next;
    logic car_stopped;

    //////////////////////////////////////////////////////////////////////
    // Service gating and arrival
    //////////////////////////////////////////////////////////////////////

    assign service_active = power_switch && !emergency_btn;
    assign car_stopped    = !elevator_moving;

    // Car is idle in service with work waiting
    assign car_ready = service_active && car_stopped && !queue_empty;

    // Standing at the head floor serves it, else the car is sent there
    assign arrival = car_ready && (head_floor == current_floor);
    assign go_next = car_ready && (head_floor != current_floor);

    //////////////////////////////////////////////////////////////////////
    // Sequencer command registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator       <= 1'b0;
            direction_selector      <= 1'b0;
            elevator_floor_selector <= FLOOR_1;
        end else begin
            // Held high every cycle the car should be dispatched
            activate_elevator <= go_next;
            if (go_next) begin
                elevator_floor_selector <= head_floor;
                direction_selector      <= (head_floor > current_floor);
            end
        end
    end

    // Door permissions need power and a stopped car
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && power_switch && car_stopped;
            door_close_allowed <= door_close_btn && power_switch && car_stopped;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // An emergency stops dispatch by the very next cycle
    a_no_activate_after_emergency: assert property (
        @(posedge clock) disable iff (!reset_n)
        $past(emergency_btn) |-> !activate_elevator
    ) else $error("activate_elevator raised after emergency_btn");

endmodule

/* elevator_pkg.sv */
/*
 * Elevator floor-request controller package
 * Floor count and floor codes of the 11-floor car, plus sizing of the
 * pending request queue.
 */

package elevator_pkg;

    // Car geometry
    localparam int NUM_FLOORS = 11;
    localparam int FLOOR_WIDTH = 4;

    // Floor codes of the lowest and highest landing
    localparam logic [FLOOR_WIDTH-1:0] FLOOR_1 = 4'd0;
    localparam logic [FLOOR_WIDTH-1:0] FLOOR_11 = 4'd10;

    // Request queue sizing
    // At most NUM_FLOORS distinct floors are pending, so 16 entries never fill
    localparam int QUEUE_DEPTH = 16;
    localparam int QUEUE_PTR_WIDTH = 4;
    // One bit wider than the pointers so a full queue can be counted
    localparam int QUEUE_COUNT_WIDTH = 5;

endpackage

/* files.f */
elevator_pkg.sv
request_latch.sv
request_queue.sv
car_dispatch.sv
floor_request_controller.sv
tb_floor_request_controller.sv

/* floor_request_controller.sv */
/*
 * Elevator floor-request controller
 * Top level of the 11-floor car controller. Button lights and accepted
 * floors come from the request latch, the queue holds them in arrival
 * order and dispatch drives the external car sequencer.
 */

`timescale 1ns/1ps

module floor_request_controller
    import elevator_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic [NUM_FLOORS-1:0]  floor_call_buttons,
    input  logic [NUM_FLOORS-1:0]  panel_buttons,
    input  logic                   door_open_btn,
    input  logic                   door_close_btn,
    input  logic                   emergency_btn,
    input  logic                   power_switch,
    input  logic [FLOOR_WIDTH-1:0] current_floor,
    input  logic                   elevator_moving,
    output logic [FLOOR_WIDTH-1:0] elevator_floor_selector,
    output logic                   direction_selector,
    output logic                   activate_elevator,
    output logic [NUM_FLOORS-1:0]  call_button_lights,
    output logic [NUM_FLOORS-1:0]  panel_button_lights,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);

    logic                   service_active;
    logic                   arrival;
    logic                   push_request;
    logic [FLOOR_WIDTH-1:0] push_floor;
    logic [FLOOR_WIDTH-1:0] head_floor;
    logic                   queue_empty;

    request_latch u_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .service_active      (service_active),
        .arrival             (arrival),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .push_request        (push_request),
        .push_floor          (push_floor)
    );

    request_queue u_request_queue (
        .clock        (clock),
        .reset_n      (reset_n),
        .push_request (push_request),
        .push_floor   (push_floor),
        .arrival      (arrival),
        .head_floor   (head_floor),
        .queue_empty  (queue_empty)
    );

    car_dispatch u_car_dispatch (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .elevator_moving         (elevator_moving),
        .current_floor           (current_floor),
        .head_floor              (head_floor),
        .queue_empty             (queue_empty),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .service_active          (service_active),
        .arrival                 (arrival),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

/* request_latch.sv */
/*
 * Request latch
 * Samples hall call and car panel buttons into button lights, accepts at
 * most one new floor per cycle (lowest first) and pushes it to the request
 * queue. Clears the lights of the current floor when the car serves it.
 */

`timescale 1ns/1ps

module request_latch
    import elevator_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic [NUM_FLOORS-1:0]  floor_call_buttons,
    input  logic [NUM_FLOORS-1:0]  panel_buttons,
    input  logic [FLOOR_WIDTH-1:0] current_floor,
    input  logic                   service_active,
    input  logic                   arrival,
    output logic [NUM_FLOORS-1:0]  call_button_lights,
    output logic [NUM_FLOORS-1:0]  panel_button_lights,
    output logic                   push_request,
    output logic [FLOOR_WIDTH-1:0] push_floor
);

    logic [NUM_FLOORS-1:0]  pending;
    logic [NUM_FLOORS-1:0]  pressed;
    logic [NUM_FLOORS-1:0]  set_mask;
    logic [NUM_FLOORS-1:0]  clear_mask;
    logic                   accept_valid;
    logic [FLOOR_WIDTH-1:0] accept_floor;

    // A floor waits in the queue exactly while one of its lights is on
    assign pending = call_button_lights | panel_button_lights;
    assign pressed = floor_call_buttons | panel_buttons;

    //////////////////////////////////////////////////////////////////////
    // New floor selection
    //////////////////////////////////////////////////////////////////////

    // Scan downward so the lowest qualifying floor wins
    always_comb begin
        accept_valid = 1'b0;
        accept_floor = FLOOR_1;
        for (int f = int'(FLOOR_11); f >= int'(FLOOR_1); f--) begin
            if (pressed[f] && !pending[f] &&
                (current_floor != FLOOR_WIDTH'(f))) begin
                accept_valid = 1'b1;
                accept_floor = FLOOR_WIDTH'(f);
            end
        end
    end

    // Which lights may be set and which are cleared this cycle
    always_comb begin
        set_mask   = '0;
        clear_mask = '0;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if (service_active && (current_floor != FLOOR_WIDTH'(f))) begin
                // Second button of an already queued floor lights without a push
                if (pending[f] || (accept_valid && (accept_floor == FLOOR_WIDTH'(f)))) begin
                    set_mask[f] = 1'b1;
                end
            end
            if (arrival && (current_floor == FLOOR_WIDTH'(f))) begin
                clear_mask[f] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Light and push registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
            push_request        <= 1'b0;
        end else begin
            // Set and clear never touch the same floor
            call_button_lights <= (call_button_lights | (floor_call_buttons & set_mask))
                                  & ~clear_mask;
            panel_button_lights <= (panel_button_lights | (panel_buttons & set_mask))
                                   & ~clear_mask;
            push_request <= service_active && accept_valid;
        end
    end

    // Floor handed to the queue along with push_request
    always_ff @(posedge clock) begin
        if (accept_valid) begin
            push_floor <= accept_floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // No request enters the queue while the car is out of service
    a_push_needs_service: assert property (
        @(posedge clock) disable iff (!reset_n)
        !$past(service_active) |-> !push_request
    ) else $error("push_request raised while service was inactive");

endmodule

/* request_queue.sv */
/*
 * Request queue
 * First-in first-out store of accepted target floors. The head entry is
 * the next floor to serve and is popped when the car arrives there.
 */

`timescale 1ns/1ps

module request_queue
    import elevator_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   push_request,
    input  logic [FLOOR_WIDTH-1:0] push_floor,
    input  logic                   arrival,
    output logic [FLOOR_WIDTH-1:0] head_floor,
    output logic                   queue_empty
);

    logic [FLOOR_WIDTH-1:0]       entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0]   rd_ptr;
    logic [QUEUE_PTR_WIDTH-1:0]   wr_ptr;
    logic [QUEUE_COUNT_WIDTH-1:0] count;
    logic                         queue_full;

    assign queue_empty = (count == '0);
    assign queue_full  = (count == QUEUE_COUNT_WIDTH'(QUEUE_DEPTH));
    assign head_floor  = entries[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    // Pointers wrap naturally at QUEUE_DEPTH
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_request) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (arrival) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_request, arrival})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Simultaneous push and pop leaves the count alone
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (push_request) begin
            entries[wr_ptr] <= push_floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // The request latch must never outrun the queue
    a_no_push_when_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        push_request |-> !queue_full
    ) else $error("push into a full request queue");

    // Dispatch only pops a floor that is actually queued
    a_no_pop_when_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        arrival |-> !queue_empty
    ) else $error("pop from an empty request queue");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the floor-request controller testbench with Verilator and run it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=tb_floor_request_controller
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f files.f -o "V$TOP" > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/V$TOP > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" "$SIM_LOG"; then
    echo "Result: PASS"
    exit 0
fi

echo "Result: FAIL"
exit 1

/* tb_floor_request_controller.sv */
/*
 * Testbench for the elevator floor-request controller
 * Random button, emergency and power stimulus from a fixed seed, a simple
 * car model that answers the activate strobe, and a cycle-level reference
 * model of lights, request order, dispatch and door permissions.
 */

`timescale 1ns/1ps

module tb_floor_request_controller
    import elevator_pkg::*;
();

    localparam int CLOCK_PERIOD   = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int RUN_CYCLES     = 3000;
    // Half again the stimulus length leaves ample margin for the final checks
    localparam int TIMEOUT_CYCLES = RUN_CYCLES * 3 / 2;
    localparam int TRAVEL_CYCLES  = 6;

    // Error kinds, one counter each
    localparam int ERR_LIGHTS  = 0;
    localparam int ERR_ORDER   = 1;
    localparam int ERR_DIR     = 2;
    localparam int ERR_ARRIVAL = 3;
    localparam int ERR_HALT    = 4;
    localparam int ERR_DOORS   = 5;
    localparam int NUM_KINDS   = 6;

    logic                   clock;
    logic                   reset_n;
    logic [NUM_FLOORS-1:0]  floor_call_buttons;
    logic [NUM_FLOORS-1:0]  panel_buttons;
    logic                   door_open_btn;
    logic                   door_close_btn;
    logic                   emergency_btn;
    logic                   power_switch;
    logic [FLOOR_WIDTH-1:0] current_floor;
    logic                   elevator_moving;
    logic [FLOOR_WIDTH-1:0] elevator_floor_selector;
    logic                   direction_selector;
    logic                   activate_elevator;
    logic [NUM_FLOORS-1:0]  call_button_lights;
    logic [NUM_FLOORS-1:0]  panel_button_lights;
    logic                   door_open_allowed;
    logic                   door_close_allowed;

    integer                 seed;
    int                     cycle_count;
    int                     err_count [NUM_KINDS];
    int                     total_errors;
    int                     served_count;
    int                     car_timer;
    int                     emergency_left;
    int                     power_off_left;
    logic [FLOOR_WIDTH-1:0] car_target;

    // Reference model state
    logic [NUM_FLOORS-1:0]  m_call;
    logic [NUM_FLOORS-1:0]  m_panel;
    logic                   m_push;
    logic [FLOOR_WIDTH-1:0] m_push_floor;
    logic [FLOOR_WIDTH-1:0] mq [$];
    logic                   m_activate;
    logic                   m_direction;
    logic                   m_door_open;
    logic                   m_door_close;
    logic                   m_arrived;
    logic [FLOOR_WIDTH-1:0] m_arrived_floor;
    logic                   m_halted;
    logic [FLOOR_WIDTH-1:0] m_prev_floor;
    logic [NUM_FLOORS-1:0]  seen_call;
    logic [NUM_FLOORS-1:0]  seen_panel;

    floor_request_controller u_floor_request_controller (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic report_mismatch(input int kind, input string msg);
        err_count[kind]++;
        $display("CHECK FAILED %0t: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model, advanced at every rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic advance_model();
        int                     f;
        logic                   service;
        logic                   idle_with_work;
        logic                   accept_valid;
        logic [FLOOR_WIDTH-1:0] accept_floor;
        logic [FLOOR_WIDTH-1:0] head;
        logic [NUM_FLOORS-1:0]  pending;
        logic [NUM_FLOORS-1:0]  next_call;
        logic [NUM_FLOORS-1:0]  next_panel;

        service        = power_switch && !emergency_btn;
        pending        = m_call | m_panel;
        head           = (mq.size() > 0) ? mq[0] : FLOOR_1;
        idle_with_work = service && !elevator_moving && (mq.size() > 0);
        m_arrived       = idle_with_work && (head == current_floor);
        m_arrived_floor = current_floor;
        m_halted        = !service;
        m_prev_floor    = current_floor;

        // Lowest pressed floor that is neither pending nor under the car
        accept_valid = 1'b0;
        accept_floor = FLOOR_1;
        for (f = 0; f < NUM_FLOORS; f++) begin
            if (!accept_valid && (floor_call_buttons[f] || panel_buttons[f]) &&
                !pending[f] && (current_floor != f)) begin
                accept_valid = 1'b1;
                accept_floor = FLOOR_WIDTH'(f);
            end
        end

        next_call  = m_call;
        next_panel = m_panel;
        for (f = 0; f < NUM_FLOORS; f++) begin
            if (service && (current_floor != f) &&
                (pending[f] || (accept_valid && (accept_floor == f)))) begin
                next_call[f]  = next_call[f] | floor_call_buttons[f];
                next_panel[f] = next_panel[f] | panel_buttons[f];
            end
        end
        if (m_arrived) begin
            next_call[current_floor]  = 1'b0;
            next_panel[current_floor] = 1'b0;
            void'(mq.pop_front());
            served_count++;
        end

        // Last cycle's accepted floor lands in the queue now
        if (m_push) begin
            mq.push_back(m_push_floor);
        end
        m_push       = service && accept_valid;
        m_push_floor = accept_floor;

        m_activate = idle_with_work && (head != current_floor);
        if (m_activate) begin
            m_direction = (head > current_floor);
        end
        m_door_open  = door_open_btn && power_switch && !elevator_moving;
        m_door_close = door_close_btn && power_switch && !elevator_moving;
        m_call       = next_call;
        m_panel      = next_panel;
    endtask

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            m_call      = '0;
            m_panel     = '0;
            m_push      = 1'b0;
            m_activate  = 1'b0;
            m_direction = 1'b0;
            m_door_open  = 1'b0;
            m_door_close = 1'b0;
            m_arrived   = 1'b0;
            m_halted    = 1'b0;
            mq.delete();
        end else begin
            advance_model();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks at the falling edge, where all outputs are settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (reset_n) begin
            if ((call_button_lights != m_call) || (panel_button_lights != m_panel)) begin
                report_mismatch(ERR_LIGHTS, $sformatf("lights call %b panel %b, expected %b %b",
                    call_button_lights, panel_button_lights, m_call, m_panel));
            end
            if (activate_elevator != m_activate) begin
                report_mismatch(ERR_ORDER, $sformatf("activate_elevator %b, expected %b",
                    activate_elevator, m_activate));
            end
            if (activate_elevator) begin
                if (mq.size() == 0) begin
                    report_mismatch(ERR_ORDER, "activate_elevator high with no pending floor");
                end else if (elevator_floor_selector != mq[0]) begin
                    report_mismatch(ERR_ORDER, $sformatf("target floor %0d, expected %0d",
                        elevator_floor_selector, mq[0]));
                end
                if (direction_selector != m_direction) begin
                    report_mismatch(ERR_DIR, $sformatf(
                        "direction %b for target %0d from %0d, expected %b",
                        direction_selector, elevator_floor_selector, m_prev_floor,
                        m_direction));
                end
            end
            if (m_arrived && (call_button_lights[m_arrived_floor] ||
                              panel_button_lights[m_arrived_floor])) begin
                report_mismatch(ERR_ARRIVAL, $sformatf("floor %0d still lit after arrival",
                    m_arrived_floor));
            end
            if (m_halted) begin
                if (((call_button_lights & ~seen_call) |
                     (panel_button_lights & ~seen_panel)) != '0) begin
                    report_mismatch(ERR_HALT, "light turned on while out of service");
                end
                if (activate_elevator) begin
                    report_mismatch(ERR_HALT, "activate_elevator high while out of service");
                end
            end
            if ((door_open_allowed != m_door_open) || (door_close_allowed != m_door_close)) begin
                report_mismatch(ERR_DOORS, $sformatf("doors open %b close %b, expected %b %b",
                    door_open_allowed, door_close_allowed, m_door_open, m_door_close));
            end
        end
        seen_call  = call_button_lights;
        seen_panel = panel_button_lights;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and car model
    //////////////////////////////////////////////////////////////////////

    // Car travels one floor every TRAVEL_CYCLES toward the latched target
    task automatic drive_car();
        if (elevator_moving) begin
            car_timer++;
            if (car_timer == TRAVEL_CYCLES) begin
                car_timer = 0;
                if (car_target > current_floor) begin
                    current_floor = current_floor + 1'b1;
                end else begin
                    current_floor = current_floor - 1'b1;
                end
                if (current_floor == car_target) begin
                    elevator_moving = 1'b0;
                end
            end
        end else if (activate_elevator) begin
            car_target      = elevator_floor_selector;
            car_timer       = 0;
            elevator_moving = 1'b1;
        end
    endtask

    task automatic drive_buttons();
        int f;

        for (f = 0; f < NUM_FLOORS; f++) begin
            floor_call_buttons[f] = (($random(seed) & 127) == 0);
            panel_buttons[f]      = (($random(seed) & 127) == 0);
        end
        door_open_btn  = (($random(seed) & 7) == 0);
        door_close_btn = (($random(seed) & 7) == 0);
    endtask

    // Rare emergency and power-off episodes of two to five cycles
    task automatic drive_halts();
        if (emergency_left > 0) begin
            emergency_left--;
        end else if (($random(seed) & 255) == 0) begin
            emergency_left = 2 + ($random(seed) & 3);
        end
        if (power_off_left > 0) begin
            power_off_left--;
        end else if (($random(seed) & 255) == 0) begin
            power_off_left = 2 + ($random(seed) & 3);
        end
        emergency_btn = (emergency_left > 0);
        power_switch  = (power_off_left == 0);
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed               = 32'h302be5a6;
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = FLOOR_1;
        elevator_moving    = 1'b0;
        car_target         = FLOOR_1;
        car_timer          = 0;
        emergency_left     = 0;
        power_off_left     = 0;
        cycle_count        = 0;
        served_count       = 0;
        seen_call          = '0;
        seen_panel         = '0;
        for (int k = 0; k < NUM_KINDS; k++) begin
            err_count[k] = 0;
        end

        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY reset_n = 1'b1;

        for (int n = 0; n < RUN_CYCLES; n++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            drive_car();
            drive_buttons();
            drive_halts();
        end
        @(negedge clock);
        // Let the last falling-edge checks complete first
        #(CLOCK_PERIOD / 4);

        if (served_count == 0) begin
            err_count[ERR_ARRIVAL]++;
            $display("No floor was ever served during the run");
        end
        total_errors = 0;
        for (int k = 0; k < NUM_KINDS; k++) begin
            total_errors += err_count[k];
        end
        $display("errors: lights %0d order %0d direction %0d arrival %0d halt %0d doors %0d",
            err_count[ERR_LIGHTS], err_count[ERR_ORDER], err_count[ERR_DIR],
            err_count[ERR_ARRIVAL], err_count[ERR_HALT], err_count[ERR_DOORS]);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
